// ==== sq_settings.svh ====
`ifndef SQ_SETTINGS_SVH
`define SQ_SETTINGS_SVH

// Queue depth must stay a power of two
`define SQ_DEPTH      8
`define SQ_IDX_BITS   3

// Occupancy and credit counters need one bit more than an index
`define SQ_CNT_BITS   4

// Address and data width
`define XLEN          32

// Free slots held back from dispatch
`define SQ_AF_MARGIN  1

`endif

// ==== sq_pkg.sv ====
`include "sq_settings.svh"

package sq_pkg;

    // Access size ordered so a wider size compares greater
    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_t;

    // Memory function as carried by a store
    typedef struct packed {
        logic      is_unsigned;
        mem_size_t size;
    } mem_func_t;

    // Entry index that wraps naturally at the queue depth
    typedef logic [`SQ_IDX_BITS-1:0] sq_idx_t;

endpackage

// ==== sq_pointer_ctrl.sv ====
`include "sq_settings.svh"

module sq_pointer_ctrl (
    input  logic            clock,
    input  logic            reset,
    input  logic            alloc_fire,
    input  logic            free,
    output sq_pkg::sq_idx_t head,
    output sq_pkg::sq_idx_t tail,
    output logic            almost_full
);

    // Number of allocated entries not yet freed
    logic [`SQ_CNT_BITS-1:0] count;

    // Keeps occupancy at or below depth minus margin
    assign almost_full = count >= `SQ_CNT_BITS'(`SQ_DEPTH - `SQ_AF_MARGIN);

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Pointers wrap through the index width
            if (alloc_fire) begin
                tail <= tail + 1'b1;
            end
            if (free) begin
                head <= head + 1'b1;
            end

            case ({alloc_fire, free})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // Occupancy unchanged on both or neither
                    count <= count;
                end
            endcase
        end
    end

endmodule

// ==== sq_drain_fsm.sv ====
`include "sq_settings.svh"

module sq_drain_fsm (
    input  logic clock,
    input  logic reset,
    input  logic commit,
    input  logic head_valid,
    input  logic head_ready,
    input  logic dc_accept,
    output logic dc_valid,
    output logic free,
    output logic sent
);

    typedef enum logic {
        IDLE    = 1'b0,
        REQUEST = 1'b1
    } state_t;

    state_t state;
    state_t state_next;

    // Stores committed by the ROB but not yet taken by the cache
    logic [`SQ_CNT_BITS-1:0] credit;
    logic                    head_eligible;

    assign head_eligible = (credit != '0) && head_valid && head_ready;

    // Request holds as a level until the cache accepts
    assign dc_valid = (state == REQUEST);
    assign free     = dc_valid && dc_accept;
    assign sent     = free;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (head_eligible) begin
                    state_next = REQUEST;
                end
            end
            REQUEST: begin
                // Back-pressure just keeps the request up
                if (dc_accept) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= IDLE;
            credit <= '0;
        end else begin
            state <= state_next;
            case ({commit, free})
                2'b10: begin
                    credit <= credit + 1'b1;
                end
                2'b01: begin
                    credit <= credit - 1'b1;
                end
                default: begin
                    credit <= credit;
                end
            endcase
        end
    end

endmodule

// ==== sq_entry_array.sv ====
`include "sq_settings.svh"

module sq_entry_array (
    input  logic                                          clock,
    input  logic                                          reset,
    input  sq_pkg::sq_idx_t                               head,
    input  sq_pkg::sq_idx_t                               tail,
    input  logic                                          alloc_fire,
    input  sq_pkg::mem_func_t                             alloc_func,
    input  logic                                          exec_valid,
    input  sq_pkg::sq_idx_t                               exec_idx,
    input  logic [`XLEN-1:0]                              exec_base,
    input  logic [11:0]                                   exec_imm,
    input  logic [`XLEN-1:0]                              exec_data,
    input  logic                                          free,
    output logic                                          head_valid,
    output logic                                          head_ready,
    output logic [`XLEN-1:0]                              head_addr,
    output sq_pkg::mem_func_t                             head_func,
    output logic [`XLEN-1:0]                              head_data,
    output sq_pkg::sq_idx_t                               ready_tail,
    output logic [`SQ_DEPTH-1:0]                          ent_valid,
    output logic [`SQ_DEPTH-1:0]                          ent_ready,
    output logic [`SQ_DEPTH*`XLEN-1:0]                    ent_addr,
    output logic [`SQ_DEPTH*$bits(sq_pkg::mem_func_t)-1:0] ent_func,
    output logic [`SQ_DEPTH*`XLEN-1:0]                    ent_data
);

    // Per-entry state
    logic [`SQ_DEPTH-1:0]                   valid_q;
    logic [`SQ_DEPTH-1:0]                   ready_q;
    logic [`SQ_DEPTH-1:0][`XLEN-1:0]        addr_q;
    logic [`SQ_DEPTH-1:0][`XLEN-1:0]        data_q;
    sq_pkg::mem_func_t [`SQ_DEPTH-1:0]      func_q;

    // Execute stage register
    logic                                   ex_valid;
    sq_pkg::sq_idx_t                        ex_idx;
    logic [`XLEN-1:0]                       ex_addr;
    logic [`XLEN-1:0]                       ex_data;
    logic [`XLEN-1:0]                       eff_addr;

    // Base plus sign-extended 12-bit offset
    assign eff_addr = exec_base + {{(`XLEN-12){exec_imm[11]}}, exec_imm};

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q  <= '0;
            ready_q  <= '0;
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= exec_valid;
            if (alloc_fire) begin
                valid_q[tail] <= 1'b1;
                ready_q[tail] <= 1'b0;
            end
            // Entry turns ready one edge after the exec pulse
            if (ex_valid) begin
                ready_q[ex_idx] <= 1'b1;
            end
            if (free) begin
                valid_q[head] <= 1'b0;
                ready_q[head] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        ex_idx  <= exec_idx;
        ex_addr <= eff_addr;
        ex_data <= exec_data;
        if (alloc_fire) begin
            func_q[tail] <= alloc_func;
        end
        if (ex_valid) begin
            addr_q[ex_idx] <= ex_addr;
            data_q[ex_idx] <= ex_data;
        end
    end

    // Oldest entry feeds the cache request
    assign head_valid = valid_q[head];
    assign head_ready = ready_q[head];
    assign head_addr  = addr_q[head];
    assign head_func  = func_q[head];
    assign head_data  = data_q[head];

    assign ent_valid = valid_q;
    assign ent_ready = ready_q;
    assign ent_addr  = addr_q;
    assign ent_func  = func_q;
    assign ent_data  = data_q;

    // Advance past the unbroken run of ready entries from head
    always_comb begin
        sq_pkg::sq_idx_t idx;
        logic            run;
        ready_tail = head;
        run        = 1'b1;
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            idx = head + sq_pkg::sq_idx_t'(i);
            if (run && valid_q[idx] && ready_q[idx]) begin
                ready_tail = ready_tail + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
    end

endmodule

// ==== sq_load_forward.sv ====
`include "sq_settings.svh"

module sq_load_forward (
    input  sq_pkg::sq_idx_t                               head,
    input  logic [`XLEN-1:0]                              ld_addr,
    input  sq_pkg::mem_func_t                             ld_func,
    input  sq_pkg::sq_idx_t                               ld_boundary,
    input  logic [`SQ_DEPTH-1:0]                          ent_valid,
    input  logic [`SQ_DEPTH*`XLEN-1:0]                    ent_addr,
    input  logic [`SQ_DEPTH*$bits(sq_pkg::mem_func_t)-1:0] ent_func,
    input  logic [`SQ_DEPTH*`XLEN-1:0]                    ent_data,
    input  logic [`SQ_DEPTH-1:0]                          ent_ready,
    output logic                                          fwd_valid,
    output logic [`XLEN-1:0]                              fwd_data
);

    logic [`SQ_DEPTH-1:0][`XLEN-1:0]   addr_v;
    logic [`SQ_DEPTH-1:0][`XLEN-1:0]   data_v;
    sq_pkg::mem_func_t [`SQ_DEPTH-1:0] func_v;

    assign addr_v = ent_addr;
    assign data_v = ent_data;
    assign func_v = ent_func;

    // Two naturally aligned accesses overlap when they agree at the coarser size
    function automatic logic overlaps(
        input logic [`XLEN-1:0] a_addr,
        input sq_pkg::mem_size_t a_size,
        input logic [`XLEN-1:0] b_addr,
        input sq_pkg::mem_size_t b_size
    );
        if (a_size == sq_pkg::WORD || b_size == sq_pkg::WORD) begin
            return a_addr[`XLEN-1:2] == b_addr[`XLEN-1:2];
        end else if (a_size == sq_pkg::HALF || b_size == sq_pkg::HALF) begin
            return a_addr[`XLEN-1:1] == b_addr[`XLEN-1:1];
        end
        return a_addr == b_addr;
    endfunction

    // Place store bytes in their memory lanes, zero elsewhere
    function automatic logic [`XLEN-1:0] realign(
        input logic [`XLEN-1:0] data,
        input logic [`XLEN-1:0] addr,
        input sq_pkg::mem_size_t size
    );
        logic [`XLEN-1:0] lanes;
        lanes = '0;
        case (size)
            sq_pkg::BYTE: lanes[8*addr[1:0] +: 8] = data[7:0];
            sq_pkg::HALF: lanes[16*addr[1] +: 16] = data[15:0];
            default:      lanes = data;
        endcase
        return lanes;
    endfunction

    // Oldest to youngest, so a later hit overrides an earlier one
    always_comb begin
        sq_pkg::sq_idx_t   idx;
        sq_pkg::mem_func_t s_func;
        logic              stop;
        logic              covers;
        fwd_valid = 1'b0;
        fwd_data  = '0;
        stop      = 1'b0;
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            idx    = head + sq_pkg::sq_idx_t'(i);
            s_func = func_v[idx];
            stop   = stop || (idx == ld_boundary);
            covers = s_func.size >= ld_func.size;
            if (!stop && ent_valid[idx] && ent_ready[idx]
                    && overlaps(addr_v[idx], s_func.size, ld_addr, ld_func.size)) begin
                // Partial cover from the youngest overlap kills the forward
                fwd_valid = covers;
                fwd_data  = covers ? realign(data_v[idx], addr_v[idx], s_func.size) : '0;
            end
        end
    end

endmodule

// ==== sq_top.sv ====
`include "sq_settings.svh"

module sq_top (
    input  logic              clock,
    input  logic              reset,
    // Dispatch
    input  logic              alloc_valid,
    input  sq_pkg::mem_func_t alloc_func,
    output sq_pkg::sq_idx_t   alloc_idx,
    // Store unit
    input  logic              exec_valid,
    input  sq_pkg::sq_idx_t   exec_idx,
    input  logic [`XLEN-1:0]  exec_base,
    input  logic [11:0]       exec_imm,
    input  logic [`XLEN-1:0]  exec_data,
    // Reorder buffer
    input  logic              commit,
    output logic              sent,
    // Data cache
    output logic              dc_valid,
    output logic [`XLEN-1:0]  dc_addr,
    output sq_pkg::mem_func_t dc_func,
    output logic [`XLEN-1:0]  dc_data,
    input  logic              dc_accept,
    // Load side
    input  logic [`XLEN-1:0]  ld_addr,
    input  sq_pkg::mem_func_t ld_func,
    input  sq_pkg::sq_idx_t   ld_boundary,
    output logic              fwd_valid,
    output logic [`XLEN-1:0]  fwd_data,
    output sq_pkg::sq_idx_t   head,
    output sq_pkg::sq_idx_t   tail,
    output sq_pkg::sq_idx_t   ready_tail,
    output logic              almost_full
);

    logic                                          alloc_fire;
    logic                                          free;
    logic                                          head_valid;
    logic                                          head_ready;
    logic [`SQ_DEPTH-1:0]                          ent_valid;
    logic [`SQ_DEPTH-1:0]                          ent_ready;
    logic [`SQ_DEPTH*`XLEN-1:0]                    ent_addr;
    logic [`SQ_DEPTH*$bits(sq_pkg::mem_func_t)-1:0] ent_func;
    logic [`SQ_DEPTH*`XLEN-1:0]                    ent_data;

    // Dispatch dropped while almost full
    assign alloc_fire = alloc_valid && !almost_full;
    assign alloc_idx  = tail;

    sq_pointer_ctrl sq_pointer_ctrl_inst (
        .clock       (clock),
        .reset       (reset),
        .alloc_fire  (alloc_fire),
        .free        (free),
        .head        (head),
        .tail        (tail),
        .almost_full (almost_full)
    );

    sq_drain_fsm sq_drain_fsm_inst (
        .clock      (clock),
        .reset      (reset),
        .commit     (commit),
        .head_valid (head_valid),
        .head_ready (head_ready),
        .dc_accept  (dc_accept),
        .dc_valid   (dc_valid),
        .free       (free),
        .sent       (sent)
    );

    sq_entry_array sq_entry_array_inst (
        .clock      (clock),
        .reset      (reset),
        .head       (head),
        .tail       (tail),
        .alloc_fire (alloc_fire),
        .alloc_func (alloc_func),
        .exec_valid (exec_valid),
        .exec_idx   (exec_idx),
        .exec_base  (exec_base),
        .exec_imm   (exec_imm),
        .exec_data  (exec_data),
        .free       (free),
        .head_valid (head_valid),
        .head_ready (head_ready),
        .head_addr  (dc_addr),
        .head_func  (dc_func),
        .head_data  (dc_data),
        .ready_tail (ready_tail),
        .ent_valid  (ent_valid),
        .ent_ready  (ent_ready),
        .ent_addr   (ent_addr),
        .ent_func   (ent_func),
        .ent_data   (ent_data)
    );

    sq_load_forward sq_load_forward_inst (
        .head        (head),
        .ld_addr     (ld_addr),
        .ld_func     (ld_func),
        .ld_boundary (ld_boundary),
        .ent_valid   (ent_valid),
        .ent_addr    (ent_addr),
        .ent_func    (ent_func),
        .ent_data    (ent_data),
        .ent_ready   (ent_ready),
        .fwd_valid   (fwd_valid),
        .fwd_data    (fwd_data)
    );

endmodule

// ==== tb_sq_top.sv ====
`include "sq_settings.svh"

module tb_sq_top;

    localparam int NUM_STORES    = 300;
    localparam int CYCLES_PER_OP = 40;
    localparam int CLOCK_PERIOD  = 100;

    logic              clock;
    logic              reset;
    logic              alloc_valid;
    sq_pkg::mem_func_t alloc_func;
    sq_pkg::sq_idx_t   alloc_idx;
    logic              exec_valid;
    sq_pkg::sq_idx_t   exec_idx;
    logic [`XLEN-1:0]  exec_base;
    logic [11:0]       exec_imm;
    logic [`XLEN-1:0]  exec_data;
    logic              commit;
    logic              sent;
    logic              dc_valid;
    logic [`XLEN-1:0]  dc_addr;
    sq_pkg::mem_func_t dc_func;
    logic [`XLEN-1:0]  dc_data;
    logic              dc_accept;
    logic [`XLEN-1:0]  ld_addr;
    sq_pkg::mem_func_t ld_func;
    sq_pkg::sq_idx_t   ld_boundary;
    logic              fwd_valid;
    logic [`XLEN-1:0]  fwd_data;
    sq_pkg::sq_idx_t   head;
    sq_pkg::sq_idx_t   tail;
    sq_pkg::sq_idx_t   ready_tail;
    logic              almost_full;

    // Reference queue state as seen between two rising edges
    logic              m_valid [`SQ_DEPTH];
    logic              m_ready [`SQ_DEPTH];
    logic              m_issued [`SQ_DEPTH];
    logic [`XLEN-1:0]  m_addr [`SQ_DEPTH];
    logic [`XLEN-1:0]  m_data [`SQ_DEPTH];
    sq_pkg::mem_func_t m_func [`SQ_DEPTH];
    sq_pkg::sq_idx_t   m_head;
    sq_pkg::sq_idx_t   m_tail;
    int                m_count;
    int                m_credit;
    logic              m_request;
    // Execute packet waiting one cycle before it lands in its entry
    logic              p_valid;
    sq_pkg::sq_idx_t   p_idx;
    logic [`XLEN-1:0]  p_addr;
    logic [`XLEN-1:0]  p_data;
    // Address the current exec packet is meant to reach
    logic [`XLEN-1:0]  exec_target;

    int                allocated;
    int                cycle;
    int                error_count;
    int                check_count;
    int                write_count;
    int                commit_count;
    int                sent_count;
    logic              finished;
    logic              prev_dc_valid;
    logic [`XLEN-1:0]  prev_addr;
    sq_pkg::mem_func_t prev_func;
    logic [`XLEN-1:0]  prev_data;

    sq_top sq_top_inst (
        .clock       (clock),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_func  (alloc_func),
        .alloc_idx   (alloc_idx),
        .exec_valid  (exec_valid),
        .exec_idx    (exec_idx),
        .exec_base   (exec_base),
        .exec_imm    (exec_imm),
        .exec_data   (exec_data),
        .commit      (commit),
        .sent        (sent),
        .dc_valid    (dc_valid),
        .dc_addr     (dc_addr),
        .dc_func     (dc_func),
        .dc_data     (dc_data),
        .dc_accept   (dc_accept),
        .ld_addr     (ld_addr),
        .ld_func     (ld_func),
        .ld_boundary (ld_boundary),
        .fwd_valid   (fwd_valid),
        .fwd_data    (fwd_data),
        .head        (head),
        .tail        (tail),
        .ready_tail  (ready_tail),
        .almost_full (almost_full)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Byte lanes an aligned access touches within its word
    function automatic logic [3:0] lane_mask(input logic [1:0] offset,
                                             input sq_pkg::mem_size_t size);
        case (size)
            sq_pkg::BYTE: return 4'b0001 << offset;
            sq_pkg::HALF: return 4'b0011 << {offset[1], 1'b0};
            default:      return 4'b1111;
        endcase
    endfunction

    // Top bit is the forward flag and the rest the data in its memory lanes
    function automatic logic [`XLEN:0] expected_forward(input logic [`XLEN-1:0] addr,
                                                        input sq_pkg::mem_func_t func,
                                                        input sq_pkg::sq_idx_t boundary);
        sq_pkg::sq_idx_t  idx;
        logic [3:0]       s_mask;
        logic [3:0]       l_mask;
        logic [`XLEN-1:0] shifted;
        logic             hit;
        logic [`XLEN-1:0] result;
        hit    = 1'b0;
        result = '0;
        l_mask = lane_mask(addr[1:0], func.size);
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            idx = m_head + sq_pkg::sq_idx_t'(i);
            if (idx == boundary) begin
                break;
            end
            s_mask = lane_mask(m_addr[idx][1:0], m_func[idx].size);
            if (m_valid[idx] && m_ready[idx] && m_addr[idx][`XLEN-1:2] == addr[`XLEN-1:2]
                    && (s_mask & l_mask) != 4'b0000) begin
                // Youngest overlap decides and must cover every load byte
                hit     = (l_mask & ~s_mask) == 4'b0000;
                shifted = m_data[idx] << (8 * m_addr[idx][1:0]);
                result  = hit ? shifted & {{8{s_mask[3]}}, {8{s_mask[2]}},
                                           {8{s_mask[1]}}, {8{s_mask[0]}}} : '0;
            end
        end
        return {hit, result};
    endfunction

    function automatic sq_pkg::sq_idx_t expected_ready_tail();
        sq_pkg::sq_idx_t idx;
        idx = m_head;
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            if (!(m_valid[idx] && m_ready[idx])) begin
                break;
            end
            idx = idx + 1'b1;
        end
        return idx;
    endfunction

    function automatic sq_pkg::mem_func_t random_func();
        sq_pkg::mem_func_t func;
        func.is_unsigned = 1'($urandom % 2);
        func.size        = sq_pkg::mem_size_t'(2'($urandom % 3));
        return func;
    endfunction

    // Small window so loads and stores often hit the same words
    function automatic logic [`XLEN-1:0] random_addr(input sq_pkg::mem_size_t size);
        logic [`XLEN-1:0] addr;
        addr = 32'h0000_4000 + ($urandom % 24);
        if (size == sq_pkg::WORD) begin
            addr[1:0] = 2'b00;
        end else if (size == sq_pkg::HALF) begin
            addr[0] = 1'b0;
        end
        return addr;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            m_valid[i]  = 1'b0;
            m_ready[i]  = 1'b0;
            m_issued[i] = 1'b0;
        end
        m_head    = '0;
        m_tail    = '0;
        m_count   = 0;
        m_credit  = 0;
        m_request = 1'b0;
        p_valid   = 1'b0;
    endtask

    // One rising edge of the queue from the inputs of the ending cycle
    task automatic update_model();
        logic fire;
        logic free;
        logic eligible;
        fire     = alloc_valid && (m_count < `SQ_DEPTH - `SQ_AF_MARGIN);
        free     = m_request && dc_accept;
        eligible = (m_credit > 0) && m_valid[m_head] && m_ready[m_head];
        if (fire) begin
            m_valid[m_tail]  = 1'b1;
            m_ready[m_tail]  = 1'b0;
            m_issued[m_tail] = 1'b0;
            m_func[m_tail]   = alloc_func;
            m_tail           = m_tail + 1'b1;
            m_count++;
            allocated++;
        end
        if (p_valid) begin
            m_ready[p_idx] = 1'b1;
            m_addr[p_idx]  = p_addr;
            m_data[p_idx]  = p_data;
        end
        if (free) begin
            m_valid[m_head] = 1'b0;
            m_ready[m_head] = 1'b0;
            m_head          = m_head + 1'b1;
            m_count--;
            m_credit--;
        end
        if (commit) begin
            m_credit++;
        end
        p_valid   = exec_valid;
        p_idx     = exec_idx;
        p_addr    = exec_target;
        p_data    = exec_data;
        m_request = m_request ? !dc_accept : eligible;
    endtask

    always @(posedge clock) begin : stimulus
        sq_pkg::sq_idx_t  idx;
        sq_pkg::sq_idx_t  start;
        logic             found;
        logic [`XLEN-1:0] target;
        logic [11:0]      imm;
        sq_pkg::mem_func_t func;
        if (reset) begin
            reset_model();
        end else begin
            update_model();
            cycle++;
            // Dispatch rate alternates so the queue both fills and drains
            alloc_valid <= (allocated < NUM_STORES)
                           && ($urandom % 100 < (((cycle / 100) % 2 == 0) ? 85 : 30));
            alloc_func  <= random_func();
            // Pick any unexecuted entry so stores complete out of order
            found = 1'b0;
            idx   = '0;
            start = sq_pkg::sq_idx_t'($urandom % `SQ_DEPTH);
            for (int i = 0; i < `SQ_DEPTH; i++) begin
                if (!found && m_valid[start] && !m_issued[start]) begin
                    found = 1'b1;
                    idx   = start;
                end
                start = start + 1'b1;
            end
            exec_valid <= 1'b0;
            if (found && ($urandom % 100 < 50)) begin
                m_issued[idx] = 1'b1;
                target        = random_addr(m_func[idx].size);
                imm           = 12'($urandom);
                exec_valid    <= 1'b1;
                exec_idx      <= idx;
                exec_imm      <= imm;
                exec_base     <= target - {{(`XLEN-12){imm[11]}}, imm};
                exec_target   <= target;
                exec_data     <= $urandom;
            end
            commit    <= (m_credit < m_count) && ($urandom % 100 < 50);
            dc_accept <= $urandom % 100 < 55;
            func      = random_func();
            ld_func   <= func;
            ld_addr   <= random_addr(func.size);
            ld_boundary <= ($urandom % 4 == 0) ? ld_boundary : m_tail;
            if (allocated >= NUM_STORES && m_count == 0) begin
                finished <= 1'b1;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [`XLEN-1:0] got,
                                   input logic [`XLEN-1:0] expected);
        $display("Error: %s got %h expected %h", name, got, expected);
        error_count++;
    endtask

    task automatic compare_outputs();
        logic [`XLEN:0] fwd;
        check_count++;
        fwd = expected_forward(ld_addr, ld_func, ld_boundary);
        if (head !== m_head) report_mismatch("head", head, m_head);
        if (tail !== m_tail) report_mismatch("tail", tail, m_tail);
        if (alloc_idx !== m_tail) report_mismatch("alloc_idx", alloc_idx, m_tail);
        if (almost_full !== (m_count >= `SQ_DEPTH - `SQ_AF_MARGIN)) begin
            report_mismatch("almost_full", almost_full, m_count >= `SQ_DEPTH - `SQ_AF_MARGIN);
        end
        if (ready_tail !== expected_ready_tail()) begin
            report_mismatch("ready_tail", ready_tail, expected_ready_tail());
        end
        if (dc_valid !== m_request) report_mismatch("dc_valid", dc_valid, m_request);
        if (sent !== (m_request && dc_accept)) report_mismatch("sent", sent, m_request && dc_accept);
        if (fwd_valid !== fwd[`XLEN]) report_mismatch("fwd_valid", fwd_valid, fwd[`XLEN]);
        if (fwd_data !== fwd[`XLEN-1:0]) report_mismatch("fwd_data", fwd_data, fwd[`XLEN-1:0]);
        if (m_request) begin
            if (dc_addr !== m_addr[m_head]) report_mismatch("dc_addr", dc_addr, m_addr[m_head]);
            if (dc_func !== m_func[m_head]) report_mismatch("dc_func", dc_func, m_func[m_head]);
            if (dc_data !== m_data[m_head]) report_mismatch("dc_data", dc_data, m_data[m_head]);
        end
        if (dc_valid && prev_dc_valid
                && (dc_addr !== prev_addr || dc_func !== prev_func || dc_data !== prev_data)) begin
            $display("Cache request changed while it was waiting for accept");
            error_count++;
        end
        if (commit) commit_count++;
        if (sent) sent_count++;
        if (dc_valid && dc_accept) begin
            write_count++;
            if (write_count > commit_count) begin
                $display("More cache writes than committed stores");
                error_count++;
            end
        end
        prev_dc_valid = dc_valid;
        prev_addr     = dc_addr;
        prev_func     = dc_func;
        prev_data     = dc_data;
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            compare_outputs();
        end
    end

    initial begin
        #(NUM_STORES * CYCLES_PER_OP * CLOCK_PERIOD);
        $display("Timeout: the queue did not drain within the time limit");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(61));
        reset         = 1'b1;
        alloc_valid   = 1'b0;
        alloc_func    = '0;
        exec_valid    = 1'b0;
        exec_idx      = '0;
        exec_base     = '0;
        exec_imm      = '0;
        exec_data     = '0;
        exec_target   = '0;
        commit        = 1'b0;
        dc_accept     = 1'b0;
        ld_addr       = '0;
        ld_func       = '0;
        ld_boundary   = '0;
        allocated     = 0;
        cycle         = 0;
        error_count   = 0;
        check_count   = 0;
        write_count   = 0;
        commit_count  = 0;
        sent_count    = 0;
        finished      = 1'b0;
        prev_dc_valid = 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (dc_valid !== 1'b0 || sent !== 1'b0 || fwd_valid !== 1'b0 || almost_full !== 1'b0
                || head !== '0 || tail !== '0 || ready_tail !== '0) begin
            $display("Outputs were not at their reset values after reset");
            error_count++;
        end
        wait (finished);
        @(negedge clock);
        if (sent_count != write_count || write_count != allocated) begin
            $display("Cache writes, sent pulses and dispatched stores do not agree");
            error_count++;
        end
        $display("Checks %0d, stores %0d, writes %0d, sent %0d, commits %0d, errors %0d",
                 check_count, allocated, write_count, sent_count, commit_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== sq_top.f ====
+incdir+.
sq_pkg.sv
sq_pointer_ctrl.sv
sq_drain_fsm.sv
sq_entry_array.sv
sq_load_forward.sv
sq_top.sv
tb_sq_top.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tb_sq_top -f sq_top.f -o sim_sq_top \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_sq_top > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && exit 0 || exit 1
